/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= ex_mem_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/cpu_params.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word and register index widths
// instruction field ranges, HALT opcode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define WORD_W 32
`define REG_W 5

// bit ranges inside an instruction word
`define OPCODE_FIELD 31:26
`define RS_FIELD 25:21
`define RT_FIELD 20:16
`define RD_FIELD 15:11
`define IMM16_FIELD 15:0
`define FUNCT_FIELD 5:0

`define OPCODE_HALT 6'h3F

`endif

/* hdl/cpu_types_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ISA level types
// data word, register index, opcode, funct and ALU operation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu_params.svh"

package cpu_types_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_W-1:0] regbits_t;

	// MIPS encodings, HALT uses the all ones opcode
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		ADDIU = 6'h09,
		ORI   = 6'h0D,
		LUI   = 6'h0F,
		LW    = 6'h23,
		SW    = 6'h2B,
		HALT  = `OPCODE_HALT
	} opcode_t;

	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		SLT  = 6'h2A
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} aluop_t;

endpackage

/* hdl/data_path_muxs_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath mux selections
// destination register and writeback source
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package data_path_muxs_pkg;

	// rd for R-type, rt for immediate and load forms
	typedef enum logic {
		SEL_RD,
		SEL_RT
	} reg_dest_mux_selection;

	typedef enum logic {
		SEL_RESULT,
		SEL_LOAD
	} mem_to_reg_mux_selection;

endpackage

/* hdl/ex_mem_reg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EX/MEM pipeline register
// holds unless enabled, flush and reset load a bubble
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_mem_reg (
	input logic CLK,
	input logic nRST,
	input logic enable,
	input logic flush,
	input cpu_types_pkg::word_t result,
	input cpu_types_pkg::word_t data_store,
	input cpu_types_pkg::regbits_t idex_rt,
	input cpu_types_pkg::regbits_t idex_rd,
	input data_path_muxs_pkg::reg_dest_mux_selection idex_reg_dest,
	input data_path_muxs_pkg::mem_to_reg_mux_selection idex_mem_to_reg,
	input logic idex_wen,
	input logic idex_dren,
	input logic idex_dwen,
	input logic idex_halt,
	output cpu_types_pkg::word_t exmem_result,
	output cpu_types_pkg::word_t exmem_data_store,
	output cpu_types_pkg::regbits_t exmem_rt,
	output cpu_types_pkg::regbits_t exmem_rd,
	output data_path_muxs_pkg::reg_dest_mux_selection exmem_reg_dest,
	output data_path_muxs_pkg::mem_to_reg_mux_selection exmem_mem_to_reg,
	output logic exmem_wen,
	output logic exmem_dren,
	output logic exmem_dwen,
	output logic exmem_halt
);
	import data_path_muxs_pkg::*;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			exmem_result <= '0;
			exmem_data_store <= '0;
			exmem_rt <= '0;
			exmem_rd <= '0;
			exmem_reg_dest <= SEL_RD;
			exmem_mem_to_reg <= SEL_RESULT;
			exmem_wen <= 1'b0;
			exmem_dren <= 1'b0;
			exmem_dwen <= 1'b0;
			exmem_halt <= 1'b0;
		end else if (flush) begin
			// flush wins over a stalled stage
			exmem_result <= '0;
			exmem_data_store <= '0;
			exmem_rt <= '0;
			exmem_rd <= '0;
			exmem_reg_dest <= SEL_RD;
			exmem_mem_to_reg <= SEL_RESULT;
			exmem_wen <= 1'b0;
			exmem_dren <= 1'b0;
			exmem_dwen <= 1'b0;
			exmem_halt <= 1'b0;
		end else if (enable) begin
			exmem_result <= result;
			exmem_data_store <= data_store;
			exmem_rt <= idex_rt;
			exmem_rd <= idex_rd;
			exmem_reg_dest <= idex_reg_dest;
			exmem_mem_to_reg <= idex_mem_to_reg;
			exmem_wen <= idex_wen;
			exmem_dren <= idex_dren;
			exmem_dwen <= idex_dwen;
			exmem_halt <= idex_halt;
		end
	end

endmodule

/* hdl/ex_mem_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute and memory half of the pipeline
// decode/ID-EX, execute, EX/MEM register, memory stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_mem_top (
	input logic CLK,
	input logic nRST,
	input logic in_req,
	input cpu_types_pkg::word_t in_instr,
	input cpu_types_pkg::word_t in_rdat1,
	input cpu_types_pkg::word_t in_rdat2,
	input logic flush,
	input logic dmem_ack,
	input cpu_types_pkg::word_t dmem_load,
	output logic in_ack,
	output logic dmem_req,
	output logic dmem_wen,
	output cpu_types_pkg::word_t dmem_addr,
	output cpu_types_pkg::word_t dmem_store,
	output logic wb_wen,
	output cpu_types_pkg::regbits_t wb_reg,
	output cpu_types_pkg::word_t wb_data,
	output logic halt
);
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;

	// stall from the memory stage
	logic mem_ready;

	// ID/EX register
	logic idex_valid;
	aluop_t idex_aluop;
	word_t idex_rdat1;
	word_t idex_rdat2;
	logic [15:0] idex_imm16;
	opcode_t idex_opcode;
	regbits_t idex_rt;
	regbits_t idex_rd;
	reg_dest_mux_selection idex_reg_dest;
	mem_to_reg_mux_selection idex_mem_to_reg;
	logic idex_wen;
	logic idex_dren;
	logic idex_dwen;
	logic idex_halt;

	// execute outputs
	word_t result;
	word_t data_store;

	// EX/MEM register
	word_t exmem_result;
	word_t exmem_data_store;
	regbits_t exmem_rt;
	regbits_t exmem_rd;
	reg_dest_mux_selection exmem_reg_dest;
	mem_to_reg_mux_selection exmem_mem_to_reg;
	logic exmem_wen;
	logic exmem_dren;
	logic exmem_dwen;
	logic exmem_halt;

	id_ex_decode u_id_ex (.*, .advance(mem_ready));

	execute_unit u_execute (.*);

	ex_mem_reg u_ex_mem (.*, .enable(mem_ready));

	mem_stage u_mem (.*);

endmodule

/* hdl/execute_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage logic
// immediate extension, operand select, ALU, store data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_params.svh"

module execute_unit (
	input cpu_types_pkg::aluop_t idex_aluop,
	input cpu_types_pkg::opcode_t idex_opcode,
	input cpu_types_pkg::word_t idex_rdat1,
	input cpu_types_pkg::word_t idex_rdat2,
	input logic [15:0] idex_imm16,
	output cpu_types_pkg::word_t result,
	output cpu_types_pkg::word_t data_store
);
	import cpu_types_pkg::*;

	word_t imm_ext;
	word_t op_b;

	// ORI zero extends, LUI places the immediate on top
	always_comb begin
		case (idex_opcode)
			ORI: imm_ext = {{(`WORD_W-16){1'b0}}, idex_imm16};
			LUI: imm_ext = {idex_imm16, {(`WORD_W-16){1'b0}}};
			default: imm_ext = {{(`WORD_W-16){idex_imm16[15]}}, idex_imm16};
		endcase
		op_b = (idex_opcode == RTYPE) ? idex_rdat2 : imm_ext;
	end

	always_comb begin
		result = '0;
		case (idex_aluop)
			ALU_ADD: result = idex_rdat1 + op_b;
			ALU_SUB: result = idex_rdat1 - op_b;
			ALU_AND: result = idex_rdat1 & op_b;
			ALU_OR: result = idex_rdat1 | op_b;
			ALU_XOR: result = idex_rdat1 ^ op_b;
			// signed compare
			ALU_SLT: result[0] = $signed(idex_rdat1) < $signed(op_b);
			ALU_LUI: result = op_b;
			default: result = '0;
		endcase
	end

	assign data_store = idex_rdat2;

endmodule

/* hdl/id_ex_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input side of the EX/MEM half
// four-phase req/ack slave, instruction decode, ID/EX register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_params.svh"

module id_ex_decode (
	input logic CLK,
	input logic nRST,
	input logic in_req,
	input cpu_types_pkg::word_t in_instr,
	input cpu_types_pkg::word_t in_rdat1,
	input cpu_types_pkg::word_t in_rdat2,
	input logic advance,
	input logic flush,
	input logic halt,
	output logic in_ack,
	output logic idex_valid,
	output cpu_types_pkg::aluop_t idex_aluop,
	output cpu_types_pkg::word_t idex_rdat1,
	output cpu_types_pkg::word_t idex_rdat2,
	output logic [15:0] idex_imm16,
	output cpu_types_pkg::opcode_t idex_opcode,
	output cpu_types_pkg::regbits_t idex_rt,
	output cpu_types_pkg::regbits_t idex_rd,
	output data_path_muxs_pkg::reg_dest_mux_selection idex_reg_dest,
	output data_path_muxs_pkg::mem_to_reg_mux_selection idex_mem_to_reg,
	output logic idex_wen,
	output logic idex_dren,
	output logic idex_dwen,
	output logic idex_halt
);
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ACK,
		WAIT_LOW
	} hs_state_t;

	hs_state_t state_reg;
	hs_state_t state_nxt;
	opcode_t opcode;
	funct_t funct;
	aluop_t aluop;
	reg_dest_mux_selection reg_dest;
	mem_to_reg_mux_selection mem_to_reg;
	logic wen;
	logic dren;
	logic dwen;
	logic is_halt;
	logic halt_passed;
	logic accept;

	// no new work once a HALT is anywhere downstream
	assign accept = in_req && (state_reg == IDLE) && !flush && !halt && !halt_passed
		&& !(idex_valid && idex_halt) && (!idex_valid || advance);

	assign in_ack = (state_reg != IDLE);

	always_comb begin
		state_nxt = state_reg;
		case (state_reg)
			IDLE: if (accept) state_nxt = ACK;
			ACK: state_nxt = in_req ? WAIT_LOW : IDLE;
			WAIT_LOW: if (!in_req) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	// decode
	always_comb begin
		opcode = opcode_t'(in_instr[`OPCODE_FIELD]);
		funct = funct_t'(in_instr[`FUNCT_FIELD]);
		aluop = ALU_ADD;
		reg_dest = SEL_RT;
		mem_to_reg = SEL_RESULT;
		wen = 1'b0;
		dren = 1'b0;
		dwen = 1'b0;
		is_halt = 1'b0;
		case (opcode)
			RTYPE: begin
				reg_dest = SEL_RD;
				wen = 1'b1;
				case (funct)
					ADDU: aluop = ALU_ADD;
					SUBU: aluop = ALU_SUB;
					AND: aluop = ALU_AND;
					OR: aluop = ALU_OR;
					XOR: aluop = ALU_XOR;
					SLT: aluop = ALU_SLT;
					// unknown funct runs as a bubble
					default: wen = 1'b0;
				endcase
			end
			ADDIU: wen = 1'b1;
			ORI: begin
				aluop = ALU_OR;
				wen = 1'b1;
			end
			LUI: begin
				aluop = ALU_LUI;
				wen = 1'b1;
			end
			LW: begin
				dren = 1'b1;
				wen = 1'b1;
				mem_to_reg = SEL_LOAD;
			end
			SW: dwen = 1'b1;
			HALT: is_halt = 1'b1;
			default: wen = 1'b0;
		endcase
	end

	// handshake state and ID/EX controls
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_reg <= IDLE;
			idex_valid <= 1'b0;
			idex_wen <= 1'b0;
			idex_dren <= 1'b0;
			idex_dwen <= 1'b0;
			idex_halt <= 1'b0;
			halt_passed <= 1'b0;
		end else begin
			state_reg <= state_nxt;
			if (accept) begin
				idex_valid <= 1'b1;
				idex_wen <= wen;
				idex_dren <= dren;
				idex_dwen <= dwen;
				idex_halt <= is_halt;
			end else if (flush || advance) begin
				// emptied register must look like a bubble to EX/MEM
				idex_valid <= 1'b0;
				idex_wen <= 1'b0;
				idex_dren <= 1'b0;
				idex_dwen <= 1'b0;
				idex_halt <= 1'b0;
			end
			if (advance && idex_valid && idex_halt && !flush) begin
				halt_passed <= 1'b1;
			end
		end
	end

	// ID/EX payload
	always_ff @(posedge CLK) begin
		if (accept) begin
			idex_aluop <= aluop;
			idex_rdat1 <= in_rdat1;
			idex_rdat2 <= in_rdat2;
			idex_imm16 <= in_instr[`IMM16_FIELD];
			idex_opcode <= opcode;
			idex_rt <= in_instr[`RT_FIELD];
			idex_rd <= in_instr[`RD_FIELD];
			idex_reg_dest <= reg_dest;
			idex_mem_to_reg <= mem_to_reg;
		end
	end

endmodule

/* hdl/mem_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output side of the EX/MEM half
// four-phase data memory master, writeback register, halt latch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_stage (
	input logic CLK,
	input logic nRST,
	input cpu_types_pkg::word_t exmem_result,
	input cpu_types_pkg::word_t exmem_data_store,
	input cpu_types_pkg::regbits_t exmem_rt,
	input cpu_types_pkg::regbits_t exmem_rd,
	input data_path_muxs_pkg::reg_dest_mux_selection exmem_reg_dest,
	input data_path_muxs_pkg::mem_to_reg_mux_selection exmem_mem_to_reg,
	input logic exmem_wen,
	input logic exmem_dren,
	input logic exmem_dwen,
	input logic exmem_halt,
	input logic dmem_ack,
	input cpu_types_pkg::word_t dmem_load,
	output logic mem_ready,
	output logic dmem_req,
	output logic dmem_wen,
	output cpu_types_pkg::word_t dmem_addr,
	output cpu_types_pkg::word_t dmem_store,
	output logic wb_wen,
	output cpu_types_pkg::regbits_t wb_reg,
	output cpu_types_pkg::word_t wb_data,
	output logic halt
);
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_ACK_LOW
	} mem_state_t;

	mem_state_t state_reg;
	regbits_t dest;
	logic mem_op;
	logic txn_load;

	assign dest = (exmem_reg_dest == SEL_RT) ? exmem_rt : exmem_rd;
	assign mem_op = exmem_dren | exmem_dwen;

	// EX/MEM only drains while no transaction is open
	assign mem_ready = (state_reg == IDLE);
	assign dmem_req = (state_reg == REQ);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_reg <= IDLE;
			txn_load <= 1'b0;
			wb_wen <= 1'b0;
			halt <= 1'b0;
		end else begin
			wb_wen <= 1'b0;
			case (state_reg)
				IDLE: begin
					if (mem_op) begin
						state_reg <= REQ;
						txn_load <= exmem_wen && (exmem_mem_to_reg == SEL_LOAD)
							&& (dest != '0);
					end else begin
						wb_wen <= exmem_wen && (dest != '0);
					end
					if (exmem_halt) begin
						halt <= 1'b1;
					end
				end
				REQ: if (dmem_ack) state_reg <= WAIT_ACK_LOW;
				WAIT_ACK_LOW: begin
					// ack low closes the transaction, load writes back now
					if (!dmem_ack) begin
						state_reg <= IDLE;
						wb_wen <= txn_load;
					end
				end
				default: state_reg <= IDLE;
			endcase
		end
	end

	// transaction and writeback payload
	always_ff @(posedge CLK) begin
		if (state_reg == IDLE) begin
			dmem_wen <= exmem_dwen;
			dmem_addr <= exmem_result;
			dmem_store <= exmem_data_store;
			wb_reg <= dest;
			wb_data <= exmem_result;
		end else if (state_reg == REQ && dmem_ack) begin
			wb_data <= dmem_load;
		end
	end

endmodule

/* sim/ex_mem_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent protocol assertions for ex_mem_top
// data memory four-phase rules, upstream ack rule, no write to register 0
// bind of the checker into the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_mem_assertions (
	input logic CLK,
	input logic nRST,
	input logic in_req,
	input logic in_ack,
	input logic dmem_req,
	input logic dmem_ack,
	input logic wb_wen,
	input cpu_types_pkg::regbits_t wb_reg
);
	int fail_count = 0;

	// request held until the memory answers
	req_held: assert property (@(posedge CLK) disable iff (!nRST)
		(dmem_req && !dmem_ack) |=> dmem_req)
		else begin
			fail_count = fail_count + 1;
			$error("dmem_req dropped before dmem_ack");
		end

	// previous transaction must be closed first
	req_after_ack_low: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(dmem_req) |-> !dmem_ack)
		else begin
			fail_count = fail_count + 1;
			$error("dmem_req rose while dmem_ack was high");
		end

	ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(in_ack) |-> in_req)
		else begin
			fail_count = fail_count + 1;
			$error("in_ack rose while in_req was low");
		end

	no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
		wb_wen |-> (wb_reg != '0))
		else begin
			fail_count = fail_count + 1;
			$error("writeback to register 0");
		end

endmodule

bind ex_mem_top ex_mem_assertions u_protocol (.*);

/* sim/ex_mem_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for ex_mem_top
// clock, reset, four-phase upstream driver, data memory model
// writeback and memory access scoreboard, watchdog, result line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "cpu_params.svh"

module ex_mem_tb;
	import cpu_types_pkg::*;

	logic CLK;
	logic nRST;
	logic in_req;
	word_t in_instr;
	word_t in_rdat1;
	word_t in_rdat2;
	logic flush;
	logic dmem_ack;
	word_t dmem_load;
	logic in_ack;
	logic dmem_req;
	logic dmem_wen;
	word_t dmem_addr;
	word_t dmem_store;
	logic wb_wen;
	regbits_t wb_reg;
	word_t wb_data;
	logic halt;

	// expected writebacks and memory accesses in issue order
	regbits_t exp_wb_reg[$];
	word_t exp_wb_data[$];
	logic exp_mem_wen[$];
	word_t exp_mem_addr[$];
	word_t exp_mem_data[$];

	// memory as seen by the model, and as predicted at issue time
	word_t mem[16];
	word_t ref_mem[16];

	word_t rng = 32'd8;
	int issued = 0;
	int flow_errors = 0;
	int check_errors = 0;
	logic req_seen = 1'b0;

	ex_mem_top DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function word_t next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// preload pattern built from the byte address
	function automatic word_t fill_word(input int i);
		return 32'hD00D_0000 ^ (word_t'(i) << 2) ^ (word_t'(i) << 24);
	endfunction

	function automatic word_t r_instr(input regbits_t rs, input regbits_t rt,
		input regbits_t rd, input funct_t fn);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic word_t i_instr(input opcode_t op, input regbits_t rs,
		input regbits_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ALU value or memory address of an instruction
	function automatic word_t model_result(input word_t instr, input word_t a, input word_t b);
		logic [15:0] imm;
		word_t sext;
		word_t res;
		imm = instr[15:0];
		sext = {{16{imm[15]}}, imm};
		case (opcode_t'(instr[31:26]))
			RTYPE: begin
				case (funct_t'(instr[5:0]))
					ADDU: res = a + b;
					SUBU: res = a - b;
					AND: res = a & b;
					OR: res = a | b;
					XOR: res = a ^ b;
					SLT: res = {31'b0, $signed(a) < $signed(b)};
					default: res = '0;
				endcase
			end
			ORI: res = a | {16'h0000, imm};
			LUI: res = {imm, 16'h0000};
			default: res = a + sext;
		endcase
		return res;
	endfunction

	function automatic void record_expected(input word_t instr, input word_t a, input word_t b);
		opcode_t op;
		regbits_t rt;
		regbits_t rd;
		word_t res;
		op = opcode_t'(instr[31:26]);
		rt = instr[20:16];
		rd = instr[15:11];
		res = model_result(instr, a, b);
		case (op)
			SW: begin
				exp_mem_wen.push_back(1'b1);
				exp_mem_addr.push_back(res);
				exp_mem_data.push_back(b);
				ref_mem[res[5:2]] = b;
			end
			LW: begin
				exp_mem_wen.push_back(1'b0);
				exp_mem_addr.push_back(res);
				exp_mem_data.push_back('0);
				if (rt != '0) begin
					exp_wb_reg.push_back(rt);
					exp_wb_data.push_back(ref_mem[res[5:2]]);
				end
			end
			HALT: begin
			end
			RTYPE: begin
				if (rd != '0) begin
					exp_wb_reg.push_back(rd);
					exp_wb_data.push_back(res);
				end
			end
			default: begin
				if (rt != '0) begin
					exp_wb_reg.push_back(rt);
					exp_wb_data.push_back(res);
				end
			end
		endcase
	endfunction

	function automatic void show_mismatch(input string name, input word_t expv, input word_t got);
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expv, got);
	endfunction

	task automatic wait_ack(input logic level);
		do @(negedge CLK); while (in_ack !== level);
	endtask

	// full four-phase handshake for one instruction
	task automatic issue(input word_t instr, input word_t a, input word_t b);
		record_expected(instr, a, b);
		issued = issued + 1;
		@(posedge CLK);
		in_req <= 1'b1;
		in_instr <= instr;
		in_rdat1 <= a;
		in_rdat2 <= b;
		wait_ack(1'b1);
		@(posedge CLK);
		in_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic drain();
		while (exp_wb_reg.size() != 0 || exp_mem_addr.size() != 0 || dmem_req || dmem_ack)
			@(negedge CLK);
		repeat (2) @(negedge CLK);
	endtask

	// ack rises on the first edge into an empty pipeline and flush follows it
	task automatic issue_flushed(input word_t instr, input word_t a, input word_t b);
		issued = issued + 1;
		@(posedge CLK);
		in_req <= 1'b1;
		in_instr <= instr;
		in_rdat1 <= a;
		in_rdat2 <= b;
		@(posedge CLK);
		flush <= 1'b1;
		@(negedge CLK);
		if (!in_ack) begin
			$display("ERROR at %0t: instruction to be flushed was not accepted", $time);
			flow_errors = flow_errors + 1;
		end
		@(posedge CLK);
		flush <= 1'b0;
		in_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic offer_after_halt(input word_t instr);
		issued = issued + 1;
		@(posedge CLK);
		in_req <= 1'b1;
		in_instr <= instr;
		in_rdat1 <= 32'd1;
		in_rdat2 <= 32'd2;
		repeat (20) begin
			@(negedge CLK);
			if (in_ack) begin
				$display("ERROR at %0t: in_ack rose after halt", $time);
				flow_errors = flow_errors + 1;
			end
			if (!halt) begin
				$display("ERROR at %0t: halt dropped before reset", $time);
				flow_errors = flow_errors + 1;
			end
		end
	endtask

	// scoreboard sampled on the falling edge
	always @(negedge CLK) begin
		if (nRST && wb_wen) begin
			if (exp_wb_reg.size() == 0) begin
				$display("ERROR at %0t: writeback to r%0d with none expected", $time, wb_reg);
				check_errors = check_errors + 1;
			end else begin
				assert (wb_reg == exp_wb_reg[0]) else begin
					show_mismatch("wb_reg", word_t'(exp_wb_reg[0]), word_t'(wb_reg));
					check_errors = check_errors + 1;
				end
				assert (wb_data == exp_wb_data[0]) else begin
					show_mismatch("wb_data", exp_wb_data[0], wb_data);
					check_errors = check_errors + 1;
				end
				void'(exp_wb_reg.pop_front());
				void'(exp_wb_data.pop_front());
			end
		end
		if (nRST && dmem_req && !req_seen) begin
			if (exp_mem_addr.size() == 0) begin
				$display("ERROR at %0t: memory access at %h with none expected", $time,
					dmem_addr);
				check_errors = check_errors + 1;
			end else begin
				assert (dmem_wen == exp_mem_wen[0]) else begin
					show_mismatch("dmem_wen", word_t'(exp_mem_wen[0]), word_t'(dmem_wen));
					check_errors = check_errors + 1;
				end
				assert (dmem_addr == exp_mem_addr[0]) else begin
					show_mismatch("dmem_addr", exp_mem_addr[0], dmem_addr);
					check_errors = check_errors + 1;
				end
				assert (!exp_mem_wen[0] || dmem_store == exp_mem_data[0]) else begin
					show_mismatch("dmem_store", exp_mem_data[0], dmem_store);
					check_errors = check_errors + 1;
				end
				void'(exp_mem_wen.pop_front());
				void'(exp_mem_addr.pop_front());
				void'(exp_mem_data.pop_front());
			end
		end
		req_seen = dmem_req;
	end

	// data memory slave with 0 to 3 cycles of random delay
	initial begin : memory_model
		logic [3:0] idx;
		logic is_write;
		word_t wdata;
		int delay;
		dmem_ack <= 1'b0;
		dmem_load <= '0;
		for (int i = 0; i < 16; i++)
			mem[i] = fill_word(i);
		forever begin
			@(negedge CLK);
			if (dmem_req && !dmem_ack) begin
				idx = dmem_addr[5:2];
				is_write = dmem_wen;
				wdata = dmem_store;
				delay = int'(next_rand() % 4);
				repeat (delay) @(posedge CLK);
				@(posedge CLK);
				if (is_write)
					mem[idx] = wdata;
				else
					dmem_load <= mem[idx];
				dmem_ack <= 1'b1;
				do @(negedge CLK); while (dmem_req);
				@(posedge CLK);
				dmem_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 400 + 10 * issued) begin
			@(posedge CLK);
			cycles = cycles + 1;
		end
		$display("ERROR: run timed out after %0d cycles", cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int total;
		nRST <= 1'b0;
		in_req <= 1'b0;
		in_instr <= '0;
		in_rdat1 <= '0;
		in_rdat2 <= '0;
		flush <= 1'b0;
		for (int i = 0; i < 16; i++)
			ref_mem[i] = fill_word(i);
		repeat (3) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		assert (!in_ack && !dmem_req && !wb_wen && !halt) else begin
			$display("ERROR at %0t: outputs not idle after reset", $time);
			flow_errors = flow_errors + 1;
		end

		// one of each R-type plus a write to r0
		issue(r_instr(5'd1, 5'd2, 5'd3, ADDU), 32'h0000_1234, 32'h0000_4321);
		issue(r_instr(5'd1, 5'd2, 5'd4, SUBU), 32'h0000_0005, 32'h0000_0007);
		issue(r_instr(5'd1, 5'd2, 5'd5, AND), 32'hF0F0_1234, 32'h0FF0_FFFF);
		issue(r_instr(5'd1, 5'd2, 5'd6, OR), 32'hA000_0001, 32'h0500_0010);
		issue(r_instr(5'd1, 5'd2, 5'd7, XOR), 32'hFFFF_0000, 32'h1234_5678);
		issue(r_instr(5'd1, 5'd2, 5'd8, SLT), 32'hFFFF_FFF0, 32'h0000_0003);
		issue(r_instr(5'd1, 5'd2, 5'd9, SLT), 32'h0000_0003, 32'hFFFF_FFF0);
		issue(r_instr(5'd1, 5'd2, 5'd0, ADDU), 32'd5, 32'd6);

		// immediate forms
		issue(i_instr(ADDIU, 5'd1, 5'd10, 16'hFFFE), 32'd100, 32'd0);
		issue(i_instr(ORI, 5'd1, 5'd11, 16'h8001), 32'h1234_0000, 32'd0);
		issue(i_instr(LUI, 5'd0, 5'd12, 16'hBEEF), 32'h0000_0077, 32'd0);
		drain();

		// stores with positive and negative offset
		issue(i_instr(SW, 5'd1, 5'd2, 16'h0008), 32'h0000_0010, 32'hCAFE_F00D);
		issue(i_instr(SW, 5'd1, 5'd2, 16'hFFF8), 32'h0000_0030, 32'h0BAD_BEEF);
		drain();

		// loads with traffic queued behind them
		issue(i_instr(LW, 5'd1, 5'd13, 16'h0008), 32'h0000_0010, 32'd0);
		issue(r_instr(5'd1, 5'd2, 5'd14, ADDU), 32'd7, 32'd9);
		issue(i_instr(LW, 5'd1, 5'd15, 16'h0000), 32'h0000_003C, 32'd0);
		for (int i = 0; i < 6; i++) begin
			issue(i_instr(LW, 5'd1, regbits_t'(16 + i), 16'(i * 4)), 32'h0000_0020, 32'd0);
			issue(r_instr(5'd1, 5'd2, regbits_t'(24 + i), XOR), word_t'(i * 3),
				32'h5555_AAAA);
		end
		drain();

		// load flushed right after ack and then a normal instruction
		issue_flushed(i_instr(LW, 5'd1, 5'd12, 16'h0004), 32'h0000_0020, 32'd0);
		issue(i_instr(ORI, 5'd1, 5'd13, 16'h00F0), 32'h0000_0F00, 32'd0);
		drain();

		// after halt nothing more is taken
		issue({`OPCODE_HALT, 26'h0}, 32'd0, 32'd0);
		while (!halt) @(negedge CLK);
		offer_after_halt(r_instr(5'd1, 5'd2, 5'd3, ADDU));

		if (exp_wb_reg.size() != 0 || exp_mem_addr.size() != 0) begin
			$display("ERROR: %0d writebacks and %0d memory accesses never appeared",
				exp_wb_reg.size(), exp_mem_addr.size());
			flow_errors = flow_errors + 1;
		end
		total = flow_errors + check_errors + DUT.u_protocol.fail_count;
		$display("errors: %0d flow, %0d scoreboard, %0d protocol", flow_errors,
			check_errors, DUT.u_protocol.fail_count);
		if (total == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/cpu_types_pkg.sv
hdl/data_path_muxs_pkg.sv
hdl/id_ex_decode.sv
hdl/execute_unit.sv
hdl/ex_mem_reg.sv
hdl/mem_stage.sv
hdl/ex_mem_top.sv
sim/ex_mem_assertions.sv
sim/ex_mem_tb.sv
